// File: hdl/pf_defs.svh
/* Prefetch front end parameters
   Buffer depth, boot address and word width */

`ifndef PF_DEFS_SVH
`define PF_DEFS_SVH

// Buffer entries, also the limit on outstanding bus transactions
// Supported range is 2 to 8
`define PF_DEPTH 4

// First fetch address after reset
`define PF_BOOT_ADDR 32'h0000_0080

// Data and address width
`define PF_XLEN 32

`endif

// File: hdl/pf_pkg.sv
/* Prefetch front end package
   Prefetcher state encoding and the fetch entry carried to decode */

`include "pf_defs.svh"

package pf_pkg;

  // Prefetcher address selection state
  typedef enum logic
  {
    IDLE,
    BRANCH_WAIT
  } prefetch_state_e;

  // One fetched word with its address and pointer tag
  typedef struct packed
  {
    logic [`PF_XLEN-1:0] addr;
    logic [`PF_XLEN-1:0] rdata;
    // Set on the first word of a pointer branch
    logic                ptr;
  } fetch_entry_t;

endpackage

// File: hdl/pf_trans_if.sv
/* Transaction request channel
   Carries fetch requests from the prefetcher to the bus adapter */

`include "pf_defs.svh"

interface pf_trans_if;

  // Request valid, accepted when ready is also high
  logic                valid;
  // Acceptance from the bus side
  logic                ready;
  // Request address, may change while waiting
  logic [`PF_XLEN-1:0] addr;
  // Request is a data access (pointer fetch)
  logic                data_access;

  // Prefetcher side
  modport master
  (
    output valid,
    output addr,
    output data_access,
    input  ready
  );

  // Bus adapter side
  modport slave
  (
    input  valid,
    input  addr,
    input  data_access,
    output ready
  );

endinterface

// File: hdl/pf_prefetcher.sv
/* Prefetcher address selection
   Issues branch targets or sequential word addresses, replays stalled branches */

`include "pf_defs.svh"

module pf_prefetcher
(
  input  logic                clk,
  input  logic                rst_n,

  // From the fetch buffer
  input  logic                fetch_branch_i,
  input  logic [`PF_XLEN-1:0] fetch_branch_addr_i,
  input  logic                fetch_valid_i,
  input  logic                fetch_ptr_i,
  output logic                fetch_ready_o,
  output logic                fetch_ptr_access_o,

  // Toward the bus adapter
  pf_trans_if.master          trans
);

  pf_pkg::prefetch_state_e state_q, state_d;

  // Last issued address and its data access flag
  logic [`PF_XLEN-1:0] addr_q;
  logic [`PF_XLEN-1:0] addr_incr;
  logic                data_access_q;
  logic                accept;

  // Sequential fetch is always word sized
  assign addr_incr = {addr_q[`PF_XLEN-1:2], 2'b00} + `PF_XLEN'(4);

  // Buffer already limits outstanding requests, pass the request on
  assign trans.valid = fetch_valid_i;
  assign accept      = trans.valid && trans.ready;

  // Handshake back to the buffer
  assign fetch_ready_o      = accept;
  assign fetch_ptr_access_o = trans.data_access;

  ////////////////////////////////////////
  // Address selection FSM
  ////////////////////////////////////////

  always_comb
  begin
    state_d           = state_q;
    trans.addr        = addr_q;
    trans.data_access = data_access_q;

    case (state_q)
      pf_pkg::IDLE:
      begin
        if (fetch_branch_i)
        begin
          trans.addr        = fetch_branch_addr_i;
          trans.data_access = fetch_ptr_i;
        end
        else
        begin
          // Pointer flag never carries over to sequential words
          trans.addr        = addr_incr;
          trans.data_access = 1'b0;
        end
        // Branch target not taken by the bus yet, hold it
        if (fetch_branch_i && !accept)
        begin
          state_d = pf_pkg::BRANCH_WAIT;
        end
      end

      pf_pkg::BRANCH_WAIT:
      begin
        // Replay the held target unless a newer branch supersedes it
        if (fetch_branch_i)
        begin
          trans.addr        = fetch_branch_addr_i;
          trans.data_access = fetch_ptr_i;
        end
        // Target accepted, sequential prefetch resumes
        if (accept)
        begin
          state_d = pf_pkg::IDLE;
        end
      end

      default:
      begin
        state_d = pf_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q       <= pf_pkg::IDLE;
      // One word before boot so the first increment lands on it
      addr_q        <= `PF_BOOT_ADDR - `PF_XLEN'(4);
      data_access_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Capture on a branch so a stalled target can be replayed
      if (fetch_branch_i || accept)
      begin
        addr_q        <= trans.addr;
        data_access_q <= trans.data_access;
      end
    end
  end

endmodule

// File: hdl/pf_fetch_buffer.sv
/* Instruction fetch buffer
   FIFO toward decode with outstanding accounting, branch flush and stale response discard */

`include "pf_defs.svh"

module pf_fetch_buffer
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Control flow change from decode
  input  logic                 branch_i,
  input  logic [`PF_XLEN-1:0]  branch_addr_i,
  input  logic                 branch_ptr_i,

  // Toward the prefetcher
  output logic                 fetch_valid_o,
  output logic                 fetch_branch_o,
  output logic [`PF_XLEN-1:0]  fetch_branch_addr_o,
  output logic                 fetch_ptr_o,
  input  logic                 fetch_ready_i,

  // Responses from the bus adapter
  input  logic                 resp_valid_i,
  input  pf_pkg::fetch_entry_t resp_i,

  // Toward decode
  input  logic                 instr_req_i,
  output logic                 instr_valid_o,
  output pf_pkg::fetch_entry_t instr_o
);

  localparam int CNT_W = $clog2(`PF_DEPTH + 1);
  localparam int PTR_W = $clog2(`PF_DEPTH);
  // Room for stored plus outstanding plus discard without overflow
  localparam int SUM_W = CNT_W + 2;

  pf_pkg::fetch_entry_t fifo_mem [`PF_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q, count_d;
  // Responses expected for the current stream
  logic [CNT_W-1:0] outst_q, outst_d;
  // Responses still due from the stream before the last branch
  logic [CNT_W-1:0] discard_q, discard_d;
  logic [SUM_W-1:0] occupancy;
  // Low during reset, keeps the bus quiet until reset is released
  logic             run_q;
  logic             accept;
  logic             push;
  logic             pop;

  ////////////////////////////////////////
  // Prefetcher request
  ////////////////////////////////////////

  // Branch passes straight through
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = branch_addr_i;
  assign fetch_ptr_o         = branch_ptr_i;

  // Stored entries are gone in the branch cycle, in-flight words still count
  assign occupancy = SUM_W'(branch_i ? '0 : count_q) + SUM_W'(outst_q) + SUM_W'(discard_q);

  // Request only while every in-flight word is sure to find a slot
  assign fetch_valid_o = run_q && (occupancy < SUM_W'(`PF_DEPTH));
  assign accept        = fetch_valid_o && fetch_ready_i;

  ////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////

  // Old stream words are never handed out in the branch cycle
  assign instr_valid_o = (count_q != '0) && !branch_i;
  assign instr_o       = fifo_mem[rd_ptr_q];
  assign pop           = instr_valid_o && instr_req_i;

  // Responses belong to the old stream while discards remain
  assign push = resp_valid_i && !branch_i && (discard_q == '0);

  always_comb
  begin
    if (branch_i)
    begin
      // Everything in flight now is old stream, a same cycle accept is new
      count_d   = '0;
      outst_d   = CNT_W'(accept);
      discard_d = discard_q + outst_q - CNT_W'(resp_valid_i);
    end
    else
    begin
      count_d = count_q + CNT_W'(push) - CNT_W'(pop);
      if (resp_valid_i && (discard_q != '0))
      begin
        // Stale word dropped
        discard_d = discard_q - CNT_W'(1);
        outst_d   = outst_q + CNT_W'(accept);
      end
      else
      begin
        discard_d = discard_q;
        outst_d   = outst_q + CNT_W'(accept) - CNT_W'(resp_valid_i);
      end
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_q     <= 1'b0;
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      count_q   <= '0;
      outst_q   <= '0;
      discard_q <= '0;
    end
    else
    begin
      run_q     <= 1'b1;
      count_q   <= count_d;
      outst_q   <= outst_d;
      discard_q <= discard_d;
      if (branch_i)
      begin
        // Flush
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
      end
      else
      begin
        if (push)
        begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop)
        begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      fifo_mem[wr_ptr_q] <= resp_i;
    end
  end

endmodule

// File: hdl/pf_bus_adapter.sv
/* Instruction bus adapter
   Request/grant address phase and in-order response pairing */

`include "pf_defs.svh"

module pf_bus_adapter
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Transaction requests from the prefetcher
  pf_trans_if.slave            trans,

  // Instruction bus
  output logic                 bus_req_o,
  output logic [`PF_XLEN-1:0]  bus_addr_o,
  output logic                 bus_data_access_o,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  input  logic [`PF_XLEN-1:0]  bus_rdata_i,

  // Responses toward the fetch buffer
  output logic                 resp_valid_o,
  output pf_pkg::fetch_entry_t resp_o
);

  localparam int PTR_W = $clog2(`PF_DEPTH);

  // Address and pointer flag of each granted request, oldest first
  logic [`PF_XLEN-1:0] addr_mem [`PF_DEPTH];
  logic                ptr_mem  [`PF_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic                grant;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  assign bus_req_o  = trans.valid;
  assign bus_addr_o = trans.addr;
  // Flag only meaningful alongside a request
  assign bus_data_access_o = trans.valid && trans.data_access;

  assign trans.ready = bus_gnt_i;
  assign grant       = trans.valid && bus_gnt_i;

  ////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////

  // Bus answers in order, head of the queue owns the response
  assign resp_valid_o = bus_rvalid_i;
  always_comb
  begin
    resp_o.addr  = addr_mem[rd_ptr_q];
    resp_o.rdata = bus_rdata_i;
    resp_o.ptr   = ptr_mem[rd_ptr_q];
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (grant)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Queue storage
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      addr_mem[wr_ptr_q] <= trans.addr;
      ptr_mem[wr_ptr_q]  <= trans.data_access;
    end
  end

endmodule

// File: hdl/pf_fetch_top.sv
/* Instruction prefetch front end
   Fetch buffer, prefetcher and bus adapter */

`include "pf_defs.svh"

module pf_fetch_top
(
  input  logic                clk,
  input  logic                rst_n,

  // Decode side
  input  logic                branch_i,
  input  logic [`PF_XLEN-1:0] branch_addr_i,
  input  logic                branch_ptr_i,
  input  logic                instr_req_i,
  output logic                instr_valid_o,
  output logic [`PF_XLEN-1:0] instr_addr_o,
  output logic [`PF_XLEN-1:0] instr_rdata_o,
  output logic                instr_ptr_o,

  // Instruction bus
  output logic                bus_req_o,
  output logic [`PF_XLEN-1:0] bus_addr_o,
  output logic                bus_data_access_o,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  logic [`PF_XLEN-1:0] bus_rdata_i
);

  // Buffer to prefetcher
  logic                fetch_valid;
  logic                fetch_ready;
  logic                fetch_branch;
  logic [`PF_XLEN-1:0] fetch_branch_addr;
  logic                fetch_ptr;

  // Adapter to buffer
  logic                 resp_valid;
  pf_pkg::fetch_entry_t resp;
  pf_pkg::fetch_entry_t instr;

  pf_trans_if i_trans_if ();

  assign instr_addr_o  = instr.addr;
  assign instr_rdata_o = instr.rdata;
  assign instr_ptr_o   = instr.ptr;

  pf_fetch_buffer i_pf_fetch_buffer
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .branch_ptr_i        (branch_ptr_i),
    .fetch_valid_o       (fetch_valid),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .fetch_ptr_o         (fetch_ptr),
    .fetch_ready_i       (fetch_ready),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .instr_req_i         (instr_req_i),
    .instr_valid_o       (instr_valid_o),
    .instr_o             (instr)
  );

  // Pointer tag reaches the buffer through the adapter queue instead
  pf_prefetcher i_pf_prefetcher
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_ptr_i         (fetch_ptr),
    .fetch_ready_o       (fetch_ready),
    .fetch_ptr_access_o  (),
    .trans               (i_trans_if.master)
  );

  pf_bus_adapter i_pf_bus_adapter
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .trans             (i_trans_if.slave),
    .bus_req_o         (bus_req_o),
    .bus_addr_o        (bus_addr_o),
    .bus_data_access_o (bus_data_access_o),
    .bus_gnt_i         (bus_gnt_i),
    .bus_rvalid_i      (bus_rvalid_i),
    .bus_rdata_i       (bus_rdata_i),
    .resp_valid_o      (resp_valid),
    .resp_o            (resp)
  );

endmodule

// File: verification/pf_fetch_asserts.sv
/* Fetch front end checker
   Tracks the expected stream and bus state, bound to the top level */

`include "pf_defs.svh"

module pf_fetch_asserts
(
  input logic                clk,
  input logic                rst_n,
  input logic                branch_i,
  input logic [`PF_XLEN-1:0] branch_addr_i,
  input logic                branch_ptr_i,
  input logic                instr_req_i,
  input logic                instr_valid_o,
  input logic [`PF_XLEN-1:0] instr_addr_o,
  input logic [`PF_XLEN-1:0] instr_rdata_o,
  input logic                instr_ptr_o,
  input logic                bus_req_o,
  input logic [`PF_XLEN-1:0] bus_addr_o,
  input logic                bus_data_access_o,
  input logic                bus_gnt_i,
  input logic                bus_rvalid_i
);

  // Memory model word pattern
  localparam logic [`PF_XLEN-1:0] DATA_KEY = 32'hA5A5_0000;

  int fail_cnt = 0;

  // Next address decode should see, and whether that word is a pointer
  logic [`PF_XLEN-1:0] exp_addr;
  logic                ptr_pend;
  // Branch target not yet granted
  logic                tgt_pend;
  logic                tgt_ptr;
  logic [`PF_XLEN-1:0] tgt_addr;
  // All granted but unanswered requests, stale ones included
  int                  out_cnt;
  int                  disc_cnt;
  // Words held in the buffer
  int                  words;
  logic                acc;
  logic                push;
  logic                pop;
  logic                exp_da;
  logic [`PF_XLEN-1:0] exp_data;

  assign acc      = bus_req_o && bus_gnt_i;
  assign pop      = instr_valid_o && instr_req_i;
  assign push     = bus_rvalid_i && !branch_i && (disc_cnt == 0);
  // Word the memory model holds at the expected address
  assign exp_data = exp_addr ^ DATA_KEY;
  // Data access only on the request that carries the pointer target
  assign exp_da   = bus_req_o && (branch_i ? branch_ptr_i : (tgt_pend && tgt_ptr));

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      exp_addr <= `PF_BOOT_ADDR;
      ptr_pend <= 1'b0;
      tgt_pend <= 1'b0;
      tgt_ptr  <= 1'b0;
      tgt_addr <= '0;
      out_cnt  <= 0;
      disc_cnt <= 0;
      words    <= 0;
    end
    else
    begin
      out_cnt <= out_cnt + int'(acc) - int'(bus_rvalid_i);
      if (branch_i)
      begin
        exp_addr <= branch_addr_i;
        ptr_pend <= branch_ptr_i;
        tgt_pend <= !acc;
        tgt_ptr  <= branch_ptr_i;
        tgt_addr <= branch_addr_i;
        // Everything still in flight belongs to the old stream
        disc_cnt <= out_cnt - int'(bus_rvalid_i);
        words    <= 0;
      end
      else
      begin
        if (pop)
        begin
          exp_addr <= exp_addr + 32'd4;
          ptr_pend <= 1'b0;
        end
        if (acc)
        begin
          tgt_pend <= 1'b0;
        end
        if (bus_rvalid_i && (disc_cnt != 0))
        begin
          disc_cnt <= disc_cnt - 1;
        end
        words <= words + int'(push) - int'(pop);
      end
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Quiet bus and decode side during reset
  a_reset_quiet: assert property (@(posedge clk)
      !rst_n |-> !bus_req_o && !instr_valid_o && !bus_data_access_o)
    else
    begin
      fail_cnt++;
      $error("outputs not low while reset is asserted at %0t", $time);
    end

  a_instr_addr: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid_o |-> instr_addr_o == exp_addr)
    else
    begin
      fail_cnt++;
      $error("mismatch %0t instr_addr_o exp %h got %h", $time,
             $sampled(exp_addr), $sampled(instr_addr_o));
    end

  a_instr_data: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid_o |-> instr_rdata_o == exp_data)
    else
    begin
      fail_cnt++;
      $error("mismatch %0t instr_rdata_o exp %h got %h", $time,
             $sampled(exp_data), $sampled(instr_rdata_o));
    end

  a_instr_ptr: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid_o |-> instr_ptr_o == ptr_pend)
    else
    begin
      fail_cnt++;
      $error("mismatch %0t instr_ptr_o exp %b got %b", $time,
             $sampled(ptr_pend), $sampled(instr_ptr_o));
    end

  // A stored word shows up at once, none is lost
  a_instr_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !branch_i |-> instr_valid_o == (words != 0))
    else
    begin
      fail_cnt++;
      $error("mismatch %0t instr_valid_o exp %b got %b", $time,
             $sampled(words != 0), $sampled(instr_valid_o));
    end

  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
      out_cnt + words <= `PF_DEPTH)
    else
    begin
      fail_cnt++;
      $error("mismatch %0t occupancy limit %0d got %0d", $time,
             `PF_DEPTH, $sampled(out_cnt + words));
    end

  a_data_access: assert property (@(posedge clk) disable iff (!rst_n)
      bus_data_access_o == exp_da)
    else
    begin
      fail_cnt++;
      $error("mismatch %0t bus_data_access_o exp %b got %b", $time,
             $sampled(exp_da), $sampled(bus_data_access_o));
    end

  // New target goes out in the branch cycle, or is replayed later
  a_branch_addr: assert property (@(posedge clk) disable iff (!rst_n)
      (branch_i || tgt_pend) && bus_req_o |->
        bus_addr_o == (branch_i ? branch_addr_i : tgt_addr))
    else
    begin
      fail_cnt++;
      $error("mismatch %0t bus_addr_o exp %h got %h", $time,
             $sampled(branch_i ? branch_addr_i : tgt_addr), $sampled(bus_addr_o));
    end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req_o && !bus_gnt_i |=> bus_req_o)
    else
    begin
      fail_cnt++;
      $error("bus_req_o dropped before a grant at %0t", $time);
    end

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req_o && !bus_gnt_i |=> branch_i || (bus_addr_o == $past(bus_addr_o)))
    else
    begin
      fail_cnt++;
      $error("mismatch %0t bus_addr_o exp %h got %h", $time,
             $past(bus_addr_o), $sampled(bus_addr_o));
    end

endmodule

bind pf_fetch_top pf_fetch_asserts i_pf_fetch_asserts
(
  .clk               (clk),
  .rst_n             (rst_n),
  .branch_i          (branch_i),
  .branch_addr_i     (branch_addr_i),
  .branch_ptr_i      (branch_ptr_i),
  .instr_req_i       (instr_req_i),
  .instr_valid_o     (instr_valid_o),
  .instr_addr_o      (instr_addr_o),
  .instr_rdata_o     (instr_rdata_o),
  .instr_ptr_o       (instr_ptr_o),
  .bus_req_o         (bus_req_o),
  .bus_addr_o        (bus_addr_o),
  .bus_data_access_o (bus_data_access_o),
  .bus_gnt_i         (bus_gnt_i),
  .bus_rvalid_i      (bus_rvalid_i)
);

// File: verification/tb_pf_fetch.sv
/* Prefetch front end testbench
   Bus memory model with random grant and response delay, branch stimulus */

module tb_pf_fetch;

  // Five tests, none longer than 400 cycles
  localparam int TIMEOUT_CYCLES = 5 * 400;
  // Each memory word is its address with this pattern XORed in
  localparam logic [31:0] DATA_KEY = 32'hA5A5_0000;

  logic        clk = 1'b0;
  logic        rst_n = 1'b1;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        branch_ptr_i;
  logic        instr_req_i;
  logic        instr_valid_o;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_o;
  logic        instr_ptr_o;
  logic        bus_req_o;
  logic [31:0] bus_addr_o;
  logic        bus_data_access_o;
  logic        bus_gnt_i = 1'b0;
  logic        bus_rvalid_i = 1'b0;
  logic [31:0] bus_rdata_i = '0;

  integer      seed = 5;
  // Forces the bus grant low
  logic        gnt_hold = 1'b0;
  int          cycles = 0;
  int          last_due = 0;
  int          due;
  int          grants = 0;
  int          tests_done = 0;
  int          words_consumed = 0;
  int          fails;
  // Granted addresses waiting for a response, and the cycle each is due
  logic [31:0] rsp_addr [$];
  int          rsp_due  [$];

  pf_fetch_top i_pf_fetch_top (.*);

  initial
  begin
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////

  // Grant about three cycles in four
  always @(negedge clk)
  begin
    bus_gnt_i = !gnt_hold && (($random(seed) & 3) != 0);
  end

  always @(posedge clk)
  begin
    cycles++;
    if (rst_n && bus_req_o && bus_gnt_i)
    begin
      grants++;
      // 0 to 3 cycles after the grant, never ahead of an older response
      due = cycles + ($random(seed) & 3);
      if (due <= last_due)
      begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_addr.push_back(bus_addr_o);
      rsp_due.push_back(due);
    end
  end

  always @(negedge clk)
  begin
    if ((rsp_addr.size() != 0) && (rsp_due[0] <= cycles))
    begin
      bus_rvalid_i = 1'b1;
      bus_rdata_i  = rsp_addr.pop_front() ^ DATA_KEY;
      void'(rsp_due.pop_front());
    end
    else
    begin
      bus_rvalid_i = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Keep decode asking until n words are taken
  task automatic consume_words(input int n);
    int got;
    got = 0;
    @(negedge clk);
    instr_req_i = 1'b1;
    while (got < n)
    begin
      @(posedge clk);
      if (instr_valid_o && instr_req_i)
      begin
        got++;
      end
    end
    @(negedge clk);
    instr_req_i = 1'b0;
    words_consumed += n;
  endtask

  // One cycle branch pulse
  task automatic take_branch(input logic [31:0] target, input logic ptr);
    @(negedge clk);
    branch_i      = 1'b1;
    branch_addr_i = target;
    branch_ptr_i  = ptr;
    @(negedge clk);
    branch_i      = 1'b0;
    branch_ptr_i  = 1'b0;
  endtask

  // Changed on the rising edge, the grant driver picks it up at the next falling edge
  task automatic hold_grant(input logic hold);
    @(posedge clk);
    gnt_hold = hold;
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("test %0d %s finished at %0t, assertion failures so far %0d",
             tests_done, name, $time, i_pf_fetch_top.i_pf_fetch_asserts.fail_cnt);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial
  begin
    branch_i      = 1'b0;
    branch_addr_i = '0;
    branch_ptr_i  = 1'b0;
    instr_req_i   = 1'b0;
    rst_n         = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    consume_words(12);
    report_test("boot stream");

    // Buffer fills and stops requesting
    idle_cycles(30);
    consume_words(8);
    report_test("stalled consumer");

    take_branch(32'h0000_1000, 1'b0);
    consume_words(6);
    take_branch(32'h0000_2040, 1'b0);
    idle_cycles(1);
    // Second branch lands while old responses may still be in flight
    take_branch(32'h0000_0400, 1'b0);
    consume_words(6);
    report_test("branches");

    take_branch(32'h0000_3000, 1'b1);
    consume_words(6);
    report_test("pointer branch");

    hold_grant(1'b1);
    idle_cycles(4);
    take_branch(32'h0000_4000, 1'b1);
    idle_cycles(5);
    // Replaces the stalled pointer target
    take_branch(32'h0000_5000, 1'b0);
    idle_cycles(5);
    hold_grant(1'b0);
    consume_words(6);
    report_test("branch during grant stall");

    fails = i_pf_fetch_top.i_pf_fetch_asserts.fail_cnt;
    $display("tests %0d, words consumed %0d, bus grants %0d, assertion failures %0d",
             tests_done, words_consumed, grants, fails);
    if (fails == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    int wd_cycles;
    wd_cycles = 0;
    while (wd_cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("timeout after %0d cycles, the tests did not complete", wd_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/pf_pkg.sv
hdl/pf_trans_if.sv
hdl/pf_prefetcher.sv
hdl/pf_fetch_buffer.sv
hdl/pf_bus_adapter.sv
hdl/pf_fetch_top.sv
verification/pf_fetch_asserts.sv
verification/tb_pf_fetch.sv

// File: run.sh
#!/bin/sh
# Build and run the prefetch front end testbench with Verilator

LOG=sim.log
SIM=sim_pf_fetch

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
     --top-module tb_pf_fetch -o "$SIM"; then
  echo "verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the closing report is printed
if ! ./obj_dir/"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0
